// File: eeprom_i2c_cfg.svh
`ifndef EEPROM_I2C_CFG_SVH
`define EEPROM_I2C_CFG_SVH

// CLK cycles per SCL half period, at least 2
// one SCL period is twice this
`define EEPROM_SCL_HALF 4

// device type code, top nibble of the control byte
`define EEPROM_DEV_CODE 4'b1010

// 24C16 style part: A10..A8 travel in the control byte
// as block select bits, A7..A0 follow as the word address
// byte. one device per bus, no chip select pins.
//
// bus: 1010 bbb r/w, then word address, then data

`endif

// File: eeprom_i2c_pkg.sv
`default_nettype none

package eeprom_i2c_pkg;

    typedef logic [10:0] ee_addr_t;     // 2 KB byte address
    typedef logic [7:0]  ee_byte_t;

    // bus commands from sequencer to bit engine
    typedef enum logic [2:0] {
        CMD_NONE, CMD_START, CMD_STOP, CMD_WRITE, CMD_READ
    } bit_cmd_e;

    typedef enum logic [2:0] {
        ENG_IDLE, ENG_START, ENG_SHIFT, ENG_ACK, ENG_STOP
    } eng_state_e;

    typedef enum logic [3:0] {
        CS_IDLE, CS_START, CS_CTRL_WR, CS_ADDR, CS_DATA,
        CS_RESTART, CS_CTRL_RD, CS_DATA_RD, CS_STOP, CS_DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: i2c_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_i2c_cfg.svh"

module i2c_bit_engine
    import eeprom_i2c_pkg::*;
(
    input  wire logic     CLK,
    input  wire logic     RESET,
    input  wire bit_cmd_e cmd,
    input  wire ee_byte_t tx_byte,
    input  wire logic     tx_nack,
    input  wire logic     sda_in,
    output logic          done,
    output ee_byte_t      rx_byte,
    output logic          rx_ack,
    output logic          scl,
    output logic          sda_oe
);

    localparam int HALF = `EEPROM_SCL_HALF;
    localparam int PER  = 2 * HALF;
    localparam int CW   = $clog2(PER);

    // compare values are the edge on which a change is registered,
    // so the new level shows one cycle later
    localparam logic [CW-1:0] P_SET_LOW  = CW'(HALF / 2 - 1);        // data changes mid low
    localparam logic [CW-1:0] P_RISE     = CW'(HALF - 1);
    localparam logic [CW-1:0] P_SET_HIGH = CW'(HALF + HALF / 2 - 1); // start/stop edge
    localparam logic [CW-1:0] P_SAMPLE   = CW'(HALF + HALF / 2);     // mid high
    localparam logic [CW-1:0] P_DONE     = CW'(PER - 2);
    localparam logic [CW-1:0] P_LAST     = CW'(PER - 1);

    eng_state_e      state;
    logic [CW-1:0]   cnt;       // phase within one SCL period
    logic [2:0]      bit_cnt;
    ee_byte_t        shreg;
    logic            reading;
    logic            nack_q;

    assign rx_byte = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= ENG_IDLE;
            cnt     <= '0;
            bit_cnt <= '0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (state == ENG_IDLE)
            begin
                cnt     <= '0;
                bit_cnt <= '0;
                if (cmd != CMD_NONE)
                    scl <= 1'b0;    // every condition opens with SCL low
                case (cmd)
                    CMD_START:
                        state <= ENG_START;
                    CMD_STOP:
                        state <= ENG_STOP;
                    CMD_WRITE, CMD_READ:
                        state <= ENG_SHIFT;
                    default:
                        state <= ENG_IDLE;
                endcase
            end
            else
            begin
                cnt <= (cnt == P_LAST) ? '0 : cnt + 1'b1;
                if (cnt == P_RISE)
                    scl <= 1'b1;
                if (cnt == P_DONE && state != ENG_SHIFT)
                    done <= 1'b1;

                case (state)
                    ENG_START:
                    begin
                        if (cnt == P_SET_LOW)
                            sda_oe <= 1'b0;     // SDA high before the falling edge
                        if (cnt == P_SET_HIGH)
                            sda_oe <= 1'b1;     // start, SDA falls with SCL high
                        if (cnt == P_LAST)
                            state <= ENG_IDLE;
                    end
                    ENG_STOP:
                    begin
                        if (cnt == P_SET_LOW)
                            sda_oe <= 1'b1;
                        if (cnt == P_SET_HIGH)
                            sda_oe <= 1'b0;     // stop, SDA rises with SCL high
                        if (cnt == P_LAST)
                            state <= ENG_IDLE;
                    end
                    ENG_SHIFT:
                    begin
                        if (cnt == P_SET_LOW)
                            sda_oe <= ~shreg[7];
                        if (cnt == P_LAST)
                        begin
                            scl     <= 1'b0;
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                                state <= ENG_ACK;
                        end
                    end
                    ENG_ACK:
                    begin
                        // ninth bit: slave answers a write, we answer a read
                        if (cnt == P_SET_LOW)
                            sda_oe <= reading & ~nack_q;
                        if (cnt == P_LAST)
                            state <= ENG_IDLE;  // SCL left high
                    end
                    default:
                        state <= ENG_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == ENG_IDLE)
        begin
            if (cmd == CMD_WRITE)
                shreg <= tx_byte;
            else if (cmd == CMD_READ)
                shreg <= 8'hff;     // all ones keeps SDA released
            reading <= (cmd == CMD_READ);
            nack_q  <= tx_nack;
        end
        else if (cnt == P_SAMPLE)
        begin
            if (state == ENG_SHIFT)
                shreg <= {shreg[6:0], sda_in};
            if (state == ENG_ACK)
                rx_ack <= ~sda_in;  // low level is an ack
        end
    end

    a_cmd_when_idle: assert property (@(posedge CLK) disable iff (RESET)
        (state != ENG_IDLE) |-> (cmd == CMD_NONE))
        else $error("i2c_bit_engine: command issued while busy");

    // outside start and stop, SDA may only move while SCL is low
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (state == ENG_SHIFT || state == ENG_ACK))
        |-> $stable(sda_oe))
        else $error("i2c_bit_engine: SDA changed while SCL high");

endmodule

`default_nettype wire

// File: eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_i2c_cfg.svh"

module eeprom_ctrl
    import eeprom_i2c_pkg::*;
(
    input  wire logic     CLK,
    input  wire logic     RESET,
    input  wire logic     wr,
    input  wire logic     rd,
    input  wire ee_addr_t addr,
    input  wire ee_byte_t data_in,
    input  wire logic     done,
    input  wire ee_byte_t rx_byte,
    input  wire logic     rx_ack,
    output bit_cmd_e      cmd,
    output ee_byte_t      tx_byte,
    output logic          tx_nack,
    output ee_byte_t      data_out,
    output logic          ack,
    output logic          nack_err,
    output logic          busy
);

    ctrl_state_e state;
    logic        is_rd;
    ee_addr_t    addr_q;
    ee_byte_t    data_q;
    logic        accept;
    logic        nacked;

    function automatic ee_byte_t ctrl_byte(input logic [2:0] blk, input logic rnw);
        ctrl_byte = {`EEPROM_DEV_CODE, blk, rnw};
    endfunction

    // a strobe in the ack cycle is legal, busy is already low there
    assign accept = (state == CS_IDLE || state == CS_DONE) && (wr || rd);

    // slave left SDA high after one of our bytes
    assign nacked = done && !rx_ack &&
                    (state == CS_CTRL_WR || state == CS_ADDR ||
                     state == CS_DATA || state == CS_CTRL_RD);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= CS_IDLE;
            is_rd    <= 1'b0;
            cmd      <= CMD_NONE;
            tx_nack  <= 1'b0;
            data_out <= '0;
            ack      <= 1'b0;
            nack_err <= 1'b0;
            busy     <= 1'b0;
        end
        else
        begin
            cmd     <= CMD_NONE;    // commands are single cycle
            tx_nack <= 1'b0;
            ack     <= 1'b0;
            if (nacked)
            begin
                state    <= CS_STOP;
                cmd      <= CMD_STOP;
                nack_err <= 1'b1;
            end
            else
            begin
                case (state)
                    CS_IDLE, CS_DONE:
                    begin
                        if (accept)
                        begin
                            state    <= CS_START;
                            cmd      <= CMD_START;
                            is_rd    <= !wr;    // wr wins
                            busy     <= 1'b1;
                            nack_err <= 1'b0;
                        end
                        else
                            state <= CS_IDLE;
                    end
                    CS_START:
                        if (done)
                        begin
                            state <= CS_CTRL_WR;
                            cmd   <= CMD_WRITE;
                        end
                    CS_CTRL_WR:
                        if (done)
                        begin
                            state <= CS_ADDR;
                            cmd   <= CMD_WRITE;
                        end
                    CS_ADDR:
                        if (done)
                        begin
                            if (is_rd)
                            begin
                                state <= CS_RESTART;
                                cmd   <= CMD_START;
                            end
                            else
                            begin
                                state <= CS_DATA;
                                cmd   <= CMD_WRITE;
                            end
                        end
                    CS_DATA:
                        if (done)
                        begin
                            state <= CS_STOP;
                            cmd   <= CMD_STOP;
                        end
                    CS_RESTART:
                        if (done)
                        begin
                            state <= CS_CTRL_RD;
                            cmd   <= CMD_WRITE;
                        end
                    CS_CTRL_RD:
                        if (done)
                        begin
                            state   <= CS_DATA_RD;
                            cmd     <= CMD_READ;
                            tx_nack <= 1'b1;    // single byte, NACK ends the read
                        end
                    CS_DATA_RD:
                        if (done)
                        begin
                            data_out <= rx_byte;
                            state    <= CS_STOP;
                            cmd      <= CMD_STOP;
                        end
                    CS_STOP:
                        if (done)
                        begin
                            state <= CS_DONE;
                            ack   <= 1'b1;
                            busy  <= 1'b0;
                        end
                    default:
                        state <= CS_IDLE;
                endcase
            end
        end
    end

    // request capture and the byte for the next write command
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q  <= addr;
            data_q  <= data_in;
            tx_byte <= ctrl_byte(addr[10:8], 1'b0);
        end
        else if (done)
        begin
            case (state)
                CS_CTRL_WR:
                    tx_byte <= addr_q[7:0];
                CS_ADDR:
                    tx_byte <= is_rd ? ctrl_byte(addr_q[10:8], 1'b1) : data_q;
                default:
                    tx_byte <= tx_byte;
            endcase
        end
    end

    a_strobe_idle: assert property (@(posedge CLK) disable iff (RESET)
        (wr || rd) |-> !busy)
        else $error("eeprom_ctrl: strobe while busy, request dropped");

    a_ack_pulse: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack)
        else $error("eeprom_ctrl: ack longer than one cycle");

    a_ack_not_busy: assert property (@(posedge CLK) disable iff (RESET)
        ack |-> !busy)
        else $error("eeprom_ctrl: ack with busy high");

endmodule

`default_nettype wire

// File: eeprom_i2c_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_i2c_top
    import eeprom_i2c_pkg::*;
(
    input  wire logic     CLK,
    input  wire logic     RESET,
    input  wire logic     wr,
    input  wire logic     rd,
    input  wire ee_addr_t addr,
    input  wire ee_byte_t data_in,
    output ee_byte_t      data_out,
    output logic          ack,
    output logic          nack_err,
    output logic          busy,
    output logic          scl,
    output logic          sda_oe,   // high pulls SDA low
    input  wire logic     sda_in
);

    bit_cmd_e cmd;
    ee_byte_t tx_byte;
    ee_byte_t rx_byte;
    logic     tx_nack;
    logic     done;
    logic     rx_ack;

    eeprom_ctrl u_ctrl (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .data_in(data_in),
        .done(done), .rx_byte(rx_byte), .rx_ack(rx_ack), .cmd(cmd), .tx_byte(tx_byte),
        .tx_nack(tx_nack), .data_out(data_out), .ack(ack), .nack_err(nack_err), .busy(busy)
    );

    i2c_bit_engine u_engine (
        .CLK(CLK), .RESET(RESET), .cmd(cmd), .tx_byte(tx_byte), .tx_nack(tx_nack),
        .sda_in(sda_in), .done(done), .rx_byte(rx_byte), .rx_ack(rx_ack),
        .scl(scl), .sda_oe(sda_oe)
    );

endmodule

`default_nettype wire

// File: tb_eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_i2c_cfg.svh"

module tb_eeprom_model
    import eeprom_i2c_pkg::*;
(
    input  wire logic CLK,
    input  wire logic RESET,
    input  wire logic scl,
    input  wire logic sda,
    input  wire logic nack_inject,
    output logic      sda_pull      // high pulls SDA low
);

    typedef enum logic [2:0] {
        M_IDLE, M_RECV, M_ACK, M_SEND, M_WAIT
    } model_state_e;

    ee_byte_t     mem [0:2047];
    model_state_e state;
    logic         scl_q;
    logic         sda_q;
    ee_byte_t     shreg;
    logic [3:0]   bits;
    logic [1:0]   byte_idx;     // 0 control, 1 word address, 2 data
    logic         rnw;
    ee_addr_t     ptr;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'h00;
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= M_IDLE;
            scl_q    <= 1'b1;
            sda_q    <= 1'b1;
            sda_pull <= 1'b0;
            bits     <= '0;
            byte_idx <= '0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda)
            begin
                state    <= M_RECV;     // start or repeated start
                bits     <= '0;
                byte_idx <= '0;
                sda_pull <= 1'b0;
            end
            else if (scl && scl_q && !sda_q && sda)
            begin
                state    <= M_IDLE;     // stop
                sda_pull <= 1'b0;
            end
            else if (scl && !scl_q && state == M_RECV)
            begin
                shreg <= {shreg[6:0], sda};
                bits  <= bits + 4'd1;
            end
            else if (!scl && scl_q)
            begin
                case (state)
                    M_RECV:
                        if (bits == 4'd8)
                        begin
                            bits <= '0;
                            if (byte_idx < 2'd2)
                                byte_idx <= byte_idx + 2'd1;
                            if (byte_idx == 2'd0 &&
                                (shreg[7:4] != `EEPROM_DEV_CODE || nack_inject))
                                state <= M_WAIT;    // no ack, SDA stays released
                            else
                            begin
                                sda_pull <= 1'b1;
                                state    <= M_ACK;
                            end
                            if (byte_idx == 2'd0)
                            begin
                                ptr[10:8] <= shreg[3:1];
                                rnw       <= shreg[0];
                            end
                            else if (byte_idx == 2'd1)
                                ptr[7:0] <= shreg;
                            else
                                mem[ptr] <= shreg;
                        end
                    M_ACK:
                        if (rnw)
                        begin
                            shreg    <= mem[ptr];
                            sda_pull <= ~mem[ptr][7];
                            bits     <= '0;
                            state    <= M_SEND;
                        end
                        else
                        begin
                            sda_pull <= 1'b0;
                            state    <= M_RECV;
                        end
                    M_SEND:
                        if (bits == 4'd7)
                        begin
                            sda_pull <= 1'b0;   // host answers, then stop
                            state    <= M_WAIT;
                        end
                        else
                        begin
                            shreg    <= {shreg[6:0], 1'b0};
                            sda_pull <= ~shreg[6];
                            bits     <= bits + 4'd1;
                        end
                    default:
                        state <= state;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker
    import eeprom_i2c_pkg::*;
(
    input  wire logic     CLK,
    input  wire logic     RESET,
    input  wire logic     wr,
    input  wire logic     rd,
    input  wire ee_byte_t data_out,
    input  wire logic     ack,
    input  wire logic     nack_err,
    input  wire logic     busy,
    input  wire logic     scl,
    input  wire logic     sda,
    input  wire ee_byte_t exp_data,
    input  wire logic     exp_err,
    output int            errors,
    output int            checks
);

    logic     in_txn;
    logic     op_rd;
    ee_byte_t want_data;
    logic     want_err;
    logic     ack_q;
    logic     scl_q;
    logic     sda_q;
    logic     reset_done;
    logic     last_stop;
    int       starts;
    int       stops;

    task automatic compare_value(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("** Error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("protocol failure at %0t: %s", $time, what);
    endtask

    initial
    begin
        errors = 0;
        checks = 0;
        starts = 0;
        stops  = 0;
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            in_txn     = 1'b0;
            ack_q      = 1'b0;
            scl_q      = 1'b1;
            sda_q      = 1'b1;
            reset_done = 1'b0;
        end
        else
        begin
            if (!reset_done)
            begin
                compare_value("scl", 8'h1, {7'd0, scl});
                compare_value("sda", 8'h1, {7'd0, sda});
                compare_value("ack", 8'h0, {7'd0, ack});
                compare_value("nack_err", 8'h0, {7'd0, nack_err});
                compare_value("busy", 8'h0, {7'd0, busy});
                compare_value("data_out", 8'h00, data_out);
                reset_done = 1'b1;
            end
            // SDA may only move under SCL high as a start or a stop
            if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q)
            begin
                if (!in_txn)
                    report_problem("bus condition outside a transaction");
                else if (sda === 1'b0)
                begin
                    starts++;
                    if (stops != 0)
                        report_problem("start seen after the stop of a transaction");
                end
                else
                    stops++;
                last_stop = (sda === 1'b1);
            end
            if (ack && ack_q)
                report_problem("ack stayed high for more than one cycle");
            if (in_txn && ack)
            begin
                compare_value("busy", 8'h0, {7'd0, busy});
                compare_value("data_out", want_data, data_out);
                compare_value("nack_err", {7'd0, want_err}, {7'd0, nack_err});
                compare_value("start count", (op_rd && !want_err) ? 8'd2 : 8'd1, 8'(starts));
                compare_value("stop count", 8'd1, 8'(stops));
                if (!last_stop)
                    report_problem("transaction did not end with a stop");
                in_txn = 1'b0;
            end
            else if (in_txn)
                compare_value("busy", 8'h1, {7'd0, busy});
            else if (ack)
                report_problem("ack without a request");
            if ((wr || rd) && !busy)
            begin
                in_txn    = 1'b1;
                op_rd     = !wr;    // wr wins
                want_data = exp_data;
                want_err  = exp_err;
                starts    = 0;
                stops     = 0;
                last_stop = 1'b0;
            end
            ack_q = ack;
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

`default_nettype wire

// File: tb_eeprom_i2c.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_i2c_cfg.svh"

module tb_eeprom_i2c
    import eeprom_i2c_pkg::*;
();

    // two starts, four 9-bit bytes and a stop per worst case read,
    // plus sequencing, idle gap and some slack
    localparam int TEST_CYCLES = (2 * 2 + 4 * 18 + 2) * `EEPROM_SCL_HALF + 20;

    logic     CLK;
    logic     RESET;
    logic     wr;
    logic     rd;
    ee_addr_t addr;
    ee_byte_t data_in;
    ee_byte_t data_out;
    logic     ack;
    logic     nack_err;
    logic     busy;
    logic     scl;
    logic     dut_sda_oe;
    logic     slave_sda_oe;
    wire      sda;
    logic     nack_inject;
    ee_byte_t exp_data;
    logic     exp_err;
    int       errors;
    int       checks;
    bit       loaded;

    bit       t_rd [$];
    ee_addr_t t_addr [$];
    ee_byte_t t_data [$];
    bit       t_nack [$];
    ee_byte_t t_exp [$];
    bit       t_err [$];

    assign sda = ~(dut_sda_oe | slave_sda_oe);  // open drain with pull-up

    always #50 CLK = ~CLK;

    eeprom_i2c_top UUT (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .data_in(data_in),
        .data_out(data_out), .ack(ack), .nack_err(nack_err), .busy(busy),
        .scl(scl), .sda_oe(dut_sda_oe), .sda_in(sda)
    );

    tb_eeprom_model u_model (
        .CLK(CLK), .RESET(RESET), .scl(scl), .sda(sda),
        .nack_inject(nack_inject), .sda_pull(slave_sda_oe)
    );

    tb_checker u_checker (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .data_out(data_out), .ack(ack),
        .nack_err(nack_err), .busy(busy), .scl(scl), .sda(sda), .exp_data(exp_data),
        .exp_err(exp_err), .errors(errors), .checks(checks)
    );

    task automatic load_tests();
        int         fd;
        int         n;
        string      line;
        logic [7:0] op;
        ee_addr_t   a;
        ee_byte_t   d;
        int         nk;
        ee_byte_t   e;
        int         er;
        fd = $fopen("eeprom_i2c_tests.txt", "r");
        if (fd == 0)
            return;
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#")
            begin
                n = $sscanf(line, "%c %h %h %d %h %d", op, a, d, nk, e, er);
                if (n == 6)
                begin
                    t_rd.push_back(op == "R");
                    t_addr.push_back(a);
                    t_data.push_back(d);
                    t_nack.push_back(nk != 0);
                    t_exp.push_back(e);
                    t_err.push_back(er != 0);
                end
            end
        end
        $fclose(fd);
    endtask

    // one request on the falling edge, then wait for ack
    task automatic run_test(input int i);
        int idle;
        idle = $urandom % 6;
        repeat (idle) @(negedge CLK);
        nack_inject = t_nack[i];
        exp_data    = t_exp[i];
        exp_err     = t_err[i];
        addr        = t_addr[i];
        data_in     = t_data[i];
        wr          = !t_rd[i];
        rd          = t_rd[i];
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        while (ack !== 1'b1)
            @(negedge CLK);
    endtask

    initial
    begin
        void'($urandom(80497));
        CLK         = 1'b0;
        RESET       = 1'b1;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        data_in     = '0;
        nack_inject = 1'b0;
        exp_data    = '0;
        exp_err     = 1'b0;
        loaded      = 1'b0;
        load_tests();
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        if (t_rd.size() == 0)
        begin
            $display("no tests could be read from eeprom_i2c_tests.txt");
            $display("*** TEST FAILED ***");
        end
        else
        begin
            loaded = 1'b1;
            foreach (t_rd[i])
                run_test(i);
            repeat (4) @(negedge CLK);
            $display("tests: %0d  checks: %0d  errors: %0d", t_rd.size(), checks, errors);
            if (errors == 0)
                $display("*** TEST PASSED ***");
            else
                $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial
    begin
        wait (loaded);
        repeat (t_rd.size() * TEST_CYCLES + 100) @(posedge CLK);
        $display("watchdog expired, the DUT did not finish %0d tests in time", t_rd.size());
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: eeprom_i2c_tests.txt
# op addr data nack exp_data exp_err, op is W (write) or R (read), bytes in hex
# exp_data is data_out at ack, which a write or a NACKed transfer leaves unchanged
R 000 00 0 00 0
W 000 5a 0 00 0
R 000 00 0 5a 0
W 1a3 c3 0 5a 0
R 1a3 00 0 c3 0
R 1a2 00 0 00 0
R 1a4 00 0 00 0
W 2f0 81 0 00 0
W 3ff 7e 0 00 0
R 2f0 00 0 81 0
R 3ff 00 0 7e 0
W 455 aa 0 7e 0
W 5c1 3c 0 7e 0
R 455 00 0 aa 0
W 455 12 1 aa 1
R 455 00 0 aa 0
R 5c1 00 1 aa 1
R 5c1 00 0 3c 0
W 600 ff 0 3c 0
W 7ff 01 0 3c 0
R 600 00 0 ff 0
R 7ff 00 0 01 0
R 7fe 00 0 00 0
W 000 a5 0 00 0
R 000 00 0 a5 0
R 1a3 00 0 c3 0

// File: eeprom_i2c.f
+incdir+.
eeprom_i2c_pkg.sv
i2c_bit_engine.sv
eeprom_ctrl.sv
eeprom_i2c_top.sv
tb_eeprom_model.sv
tb_checker.sv
tb_eeprom_i2c.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_eeprom_i2c \
    -f eeprom_i2c.f -o tb_eeprom_i2c || exit 1
out=$(./obj_dir/tb_eeprom_i2c)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1
